// File: Makefile
# Verilator build and run of the hazard unit testbench

VERILATOR ?= verilator
TOP       ?= hazard_unit_tb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "sim failed" $(LOG); then \
		echo "test: failure reported in $(LOG)"; \
		exit 1; \
	fi
	@if ! grep -q "sim passed" $(LOG); then \
		echo "test: run ended without a result in $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: logic/hazard_pkg.sv
package hazard_pkg;

	// rv32i base opcodes
	localparam logic [6:0] op_lui    = 7'b0110111;
	localparam logic [6:0] op_auipc  = 7'b0010111;
	localparam logic [6:0] op_jal    = 7'b1101111;
	localparam logic [6:0] op_jalr   = 7'b1100111;
	localparam logic [6:0] op_branch = 7'b1100011;
	localparam logic [6:0] op_load   = 7'b0000011;
	localparam logic [6:0] op_store  = 7'b0100011;
	localparam logic [6:0] op_imm    = 7'b0010011;
	localparam logic [6:0] op_reg    = 7'b0110011;

	localparam int cnt_w = 3; // countdown width

	localparam logic [cnt_w-1:0] lat_alu  = 3'd3; // busy cycles after an alu write
	localparam logic [cnt_w-1:0] lat_load = 3'd4; // busy cycles after a load

	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} r_fmt_t;

	typedef struct packed {
		logic [11:0] imm;
		logic [4:0]  rs1;
		logic [2:0]  funct3;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} i_fmt_t;

	typedef struct packed {
		logic [6:0] imm_hi; // imm[11:5]
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] imm_lo; // imm[4:0]
		logic [6:0] opcode;
	} s_fmt_t;

	typedef struct packed {
		logic       imm12;
		logic [5:0] imm10_5;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [3:0] imm4_1;
		logic       imm11;
		logic [6:0] opcode;
	} b_fmt_t;

	typedef struct packed {
		logic [19:0] imm; // imm[31:12]
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} u_fmt_t;

	typedef struct packed {
		logic       imm20;
		logic [9:0] imm10_1;
		logic       imm11;
		logic [7:0] imm19_12;
		logic [4:0] rd;
		logic [6:0] opcode;
	} j_fmt_t;

	// one instruction word, six views
	typedef union packed {
		r_fmt_t r_fmt;
		i_fmt_t i_fmt;
		s_fmt_t s_fmt;
		b_fmt_t b_fmt;
		u_fmt_t u_fmt;
		j_fmt_t j_fmt;
	} instr_t;

	typedef struct packed {
		logic [4:0] rs1;
		logic       use_rs1;
		logic [4:0] rs2;
		logic       use_rs2;
	} src_req_t;

	typedef struct packed {
		src_req_t   src;
		logic [4:0] rd;
		logic       writes_rd; // nonzero rd that gets written
		logic       is_load;
		logic       illegal;
	} dec_t;

	typedef struct packed {
		logic             valid;
		logic [4:0]       rd;
		logic [cnt_w-1:0] lat;
	} sb_write_t;

	typedef struct packed {
		logic             busy;
		logic [cnt_w-1:0] wait_cycles;
	} hazard_t;

endpackage

// File: logic/hazard_unit.sv
module hazard_unit (
	input  logic                         clk,
	input  logic                         nrst,
	input  logic                         instr_valid,
	input  hazard_pkg::instr_t           instr,
	input  logic                         branch_taken,
	output logic                         issue,
	output logic                         stall,
	output logic                         kill,
	output logic                         illegal,
	output logic [hazard_pkg::cnt_w-1:0] stall_cycles
);

	hazard_pkg::dec_t      dec;
	hazard_pkg::hazard_t   hz;
	hazard_pkg::sb_write_t wr;

	instr_decoder u_decoder (
		.instr (instr),
		.dec   (dec)
	);

	reg_scoreboard u_scoreboard (
		.clk  (clk),
		.nrst (nrst),
		.src  (dec.src), // source lookup only
		.wr   (wr),
		.hz   (hz)
	);

	issue_ctrl u_issue (
		.clk          (clk),
		.nrst         (nrst),
		.instr_valid  (instr_valid),
		.branch_taken (branch_taken),
		.dec          (dec),
		.hz           (hz),
		.wr           (wr),
		.issue        (issue),
		.stall        (stall),
		.kill         (kill),
		.illegal      (illegal),
		.stall_cycles (stall_cycles)
	);

endmodule

// File: logic/instr_decoder.sv
module instr_decoder (
	input  hazard_pkg::instr_t instr,
	output hazard_pkg::dec_t   dec
);

	logic [6:0] opcode;
	logic       has_rd; // format carries a destination

	assign opcode = instr.r_fmt.opcode; // same bits in every format

	always_comb
	begin
		dec = '0;
		has_rd = 1'b0;
		case (opcode)
			hazard_pkg::op_reg:
			begin
				dec.src.rs1 = instr.r_fmt.rs1;
				dec.src.use_rs1 = 1'b1;
				dec.src.rs2 = instr.r_fmt.rs2;
				dec.src.use_rs2 = 1'b1;
				dec.rd = instr.r_fmt.rd;
				has_rd = 1'b1;
			end
			hazard_pkg::op_imm:
			begin
				dec.src.rs1 = instr.i_fmt.rs1;
				dec.src.use_rs1 = 1'b1;
				dec.rd = instr.i_fmt.rd;
				has_rd = 1'b1;
			end
			hazard_pkg::op_load:
			begin
				dec.src.rs1 = instr.i_fmt.rs1;
				dec.src.use_rs1 = 1'b1;
				dec.rd = instr.i_fmt.rd;
				dec.is_load = 1'b1;
				has_rd = 1'b1;
			end
			hazard_pkg::op_jalr:
			begin
				dec.src.rs1 = instr.i_fmt.rs1;
				dec.src.use_rs1 = 1'b1;
				dec.rd = instr.i_fmt.rd;
				has_rd = 1'b1;
			end
			hazard_pkg::op_store:
			begin
				dec.src.rs1 = instr.s_fmt.rs1;
				dec.src.use_rs1 = 1'b1;
				dec.src.rs2 = instr.s_fmt.rs2; // store data
				dec.src.use_rs2 = 1'b1;
			end
			hazard_pkg::op_branch:
			begin
				dec.src.rs1 = instr.b_fmt.rs1;
				dec.src.use_rs1 = 1'b1;
				dec.src.rs2 = instr.b_fmt.rs2;
				dec.src.use_rs2 = 1'b1;
			end
			hazard_pkg::op_lui,
			hazard_pkg::op_auipc:
			begin
				dec.rd = instr.u_fmt.rd;
				has_rd = 1'b1;
			end
			hazard_pkg::op_jal:
			begin
				dec.rd = instr.j_fmt.rd;
				has_rd = 1'b1;
			end
			default:
			begin
				dec.illegal = 1'b1; // flags stay clear
			end
		endcase
		dec.writes_rd = has_rd && (dec.rd != 5'd0); // x0 is no write
	end

endmodule

// File: logic/issue_ctrl.sv
module issue_ctrl (
	input  logic                         clk,
	input  logic                         nrst,
	input  logic                         instr_valid,
	input  logic                         branch_taken,
	input  hazard_pkg::dec_t             dec,
	input  hazard_pkg::hazard_t          hz,
	output hazard_pkg::sb_write_t        wr,
	output logic                         issue,
	output logic                         stall,
	output logic                         kill,
	output logic                         illegal,
	output logic [hazard_pkg::cnt_w-1:0] stall_cycles
);

	logic kill_q; // second cycle of the squash window
	logic legal;

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			kill_q <= 1'b0;
		end
		else
		begin
			kill_q <= branch_taken; // back to back strobes keep it set
		end
	end

	assign kill = branch_taken || kill_q;
	assign legal = instr_valid && !dec.illegal;
	assign illegal = instr_valid && dec.illegal;

	assign stall = legal && hz.busy && !kill; // kill masks stall
	assign issue = legal && !hz.busy && !kill;

	assign stall_cycles = stall ? hz.wait_cycles : '0;

	// claim the destination on issue
	assign wr.valid = issue && dec.writes_rd;
	assign wr.rd = dec.rd;
	assign wr.lat = dec.is_load ? hazard_pkg::lat_load : hazard_pkg::lat_alu;

endmodule

// File: logic/reg_scoreboard.sv
module reg_scoreboard (
	input  logic                  clk,
	input  logic                  nrst,
	input  hazard_pkg::src_req_t  src,
	input  hazard_pkg::sb_write_t wr,
	output hazard_pkg::hazard_t   hz
);

	logic [hazard_pkg::cnt_w-1:0] cnt [32]; // remaining busy cycles per register

	logic [hazard_pkg::cnt_w-1:0] rs1_cnt;
	logic [hazard_pkg::cnt_w-1:0] rs2_cnt;

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			for (int i = 0; i < 32; i++)
			begin
				cnt[i] <= '0;
			end
		end
		else
		begin
			cnt[0] <= '0; // x0 never pending
			for (int i = 1; i < 32; i++)
			begin
				if (wr.valid && (wr.rd == 5'(i)))
				begin
					cnt[i] <= wr.lat; // new write wins over decrement
				end
				else if (cnt[i] != '0)
				begin
					cnt[i] <= cnt[i] - 1'b1;
				end
			end
		end
	end

	// unused sources read as idle
	always_comb
	begin
		rs1_cnt = '0;
		rs2_cnt = '0;
		if (src.use_rs1)
		begin
			rs1_cnt = cnt[src.rs1];
		end
		if (src.use_rs2)
		begin
			rs2_cnt = cnt[src.rs2];
		end
	end

	assign hz.busy = (rs1_cnt != '0) || (rs2_cnt != '0);
	assign hz.wait_cycles = (rs1_cnt > rs2_cnt) ? rs1_cnt : rs2_cnt; // longest wait

endmodule

// File: testbench/hazard_unit_assert.sv
module hazard_unit_assert (
	input logic clk,
	input logic nrst,
	input logic branch_taken,
	input logic issue,
	input logic stall,
	input logic kill,
	input logic illegal
);

	no_issue_with_stall: assert property (@(posedge clk) disable iff (!nrst)
		!(issue && stall))
		else $error("issue and stall high in the same cycle");

	kill_on_strobe: assert property (@(posedge clk) disable iff (!nrst)
		branch_taken |-> kill)
		else $error("kill low in the cycle of a branch strobe");

	kill_after_strobe: assert property (@(posedge clk) disable iff (!nrst)
		branch_taken |=> kill)
		else $error("kill low in the cycle after a branch strobe");

	no_issue_when_illegal: assert property (@(posedge clk) disable iff (!nrst)
		!(illegal && issue))
		else $error("illegal word issued");

endmodule

bind hazard_unit hazard_unit_assert u_assert (
	.clk          (clk),
	.nrst         (nrst),
	.branch_taken (branch_taken),
	.issue        (issue),
	.stall        (stall),
	.kill         (kill),
	.illegal      (illegal)
);

// File: testbench/hazard_unit_tb.sv
module hazard_unit_tb;

	localparam int reset_cycles = 8;
	localparam int directed_cycles = 200;
	localparam int random_cycles = 300;
	localparam int timeout_cycles = reset_cycles + directed_cycles + random_cycles + 100;

	localparam logic [2:0] alu_busy = 3'd3;
	localparam logic [2:0] load_busy = 3'd4;

	logic               clk = 1'b0;
	logic               nrst;
	logic               instr_valid;
	hazard_pkg::instr_t instr;
	logic               branch_taken;
	logic               issue;
	logic               stall;
	logic               kill;
	logic               illegal;
	logic [2:0]         stall_cycles;

	logic [2:0]  ref_cnt [32]; // model countdowns
	logic        ref_kill_q;
	logic [31:0] rng;
	int          err_count = 0;
	int          check_count = 0;
	int          cycle_count = 0;

	hazard_unit dut (
		.clk          (clk),
		.nrst         (nrst),
		.instr_valid  (instr_valid),
		.instr        (instr),
		.branch_taken (branch_taken),
		.issue        (issue),
		.stall        (stall),
		.kill         (kill),
		.illegal      (illegal),
		.stall_cycles (stall_cycles)
	);

	initial
	begin
		forever #2 clk = ~clk;
	end

	task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
		check_count++;
		if (act !== exp)
		begin
			err_count++;
			$display("CHECK FAILED time=%0t %s expected %0h actual %0h", $time, name, exp, act);
		end
	endtask

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic opcode_known(input logic [6:0] op);
		case (op)
			hazard_pkg::op_lui, hazard_pkg::op_auipc, hazard_pkg::op_jal,
			hazard_pkg::op_jalr, hazard_pkg::op_branch, hazard_pkg::op_load,
			hazard_pkg::op_store, hazard_pkg::op_imm, hazard_pkg::op_reg:
				return 1'b1;
			default:
				return 1'b0;
		endcase
	endfunction

	// expected outputs checked mid cycle before the state steps
	always @(negedge clk)
	begin : ref_model
		logic [31:0] raw;
		logic [6:0]  op;
		logic [4:0]  rd;
		logic [4:0]  rs1;
		logic [4:0]  rs2;
		logic        known;
		logic        use1;
		logic        use2;
		logic        writes;
		logic [2:0]  c1;
		logic [2:0]  c2;
		logic        e_kill;
		logic        e_stall;
		logic        e_issue;
		if (!nrst)
		begin
			for (int i = 0; i < 32; i++)
				ref_cnt[i] = 3'd0;
			ref_kill_q = 1'b0;
		end
		else
		begin
			raw = instr;
			op = raw[6:0];
			rd = raw[11:7];
			rs1 = raw[19:15];
			rs2 = raw[24:20];
			known = opcode_known(op);
			use1 = known && op != hazard_pkg::op_lui && op != hazard_pkg::op_auipc
				&& op != hazard_pkg::op_jal;
			use2 = op == hazard_pkg::op_reg || op == hazard_pkg::op_store
				|| op == hazard_pkg::op_branch;
			writes = known && op != hazard_pkg::op_store && op != hazard_pkg::op_branch
				&& rd != 5'd0;
			c1 = use1 ? ref_cnt[rs1] : 3'd0;
			c2 = use2 ? ref_cnt[rs2] : 3'd0;
			e_kill = branch_taken || ref_kill_q;
			e_stall = instr_valid && known && (c1 != 3'd0 || c2 != 3'd0) && !e_kill;
			e_issue = instr_valid && known && c1 == 3'd0 && c2 == 3'd0 && !e_kill;
			check("issue", 32'(e_issue), 32'(issue));
			check("stall", 32'(e_stall), 32'(stall));
			check("kill", 32'(e_kill), 32'(kill));
			check("illegal", 32'(instr_valid && !known), 32'(illegal));
			check("stall_cycles", e_stall ? 32'(c1 > c2 ? c1 : c2) : 32'd0, 32'(stall_cycles));
			for (int i = 1; i < 32; i++)
			begin
				if (e_issue && writes && rd == 5'(i))
					ref_cnt[i] = (op == hazard_pkg::op_load) ? load_busy : alu_busy;
				else if (ref_cnt[i] != 3'd0)
					ref_cnt[i] = ref_cnt[i] - 3'd1;
			end
			ref_kill_q = branch_taken;
		end
	end

	always @(posedge clk)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= timeout_cycles)
		begin
			$display("timeout: the run did not finish within %0d cycles", timeout_cycles);
			$display("sim failed");
			$finish;
		end
	end

	function automatic hazard_pkg::instr_t make_instr(input logic [6:0] op, input logic [4:0] rd,
		input logic [4:0] rs1, input logic [4:0] rs2);
		hazard_pkg::instr_t w;
		w = '0;
		w.r_fmt.opcode = op;
		w.r_fmt.rd = rd; // imm bits for s and b formats
		w.r_fmt.rs1 = rs1;
		w.r_fmt.rs2 = rs2;
		return w;
	endfunction

	// hold the word until it issues, is killed or flagged illegal
	task automatic send(input hazard_pkg::instr_t w, output int stalls, output logic got);
		logic done;
		stalls = 0;
		done = 1'b0;
		@(posedge clk);
		instr_valid <= 1'b1;
		instr <= w;
		while (!done)
		begin
			@(negedge clk);
			if (stall)
				stalls++;
			if (issue || kill || illegal)
				done = 1'b1;
		end
		got = issue;
	endtask

	task automatic idle(input int n);
		repeat (n)
		begin
			@(posedge clk);
			instr_valid <= 1'b0;
			branch_taken <= 1'b0;
		end
	endtask

	task automatic test_reset;
		int   stalls;
		logic got;
		@(negedge clk);
		check("issue after reset", 32'd0, 32'(issue));
		check("stall after reset", 32'd0, 32'(stall));
		check("kill after reset", 32'd0, 32'(kill));
		check("illegal after reset", 32'd0, 32'(illegal));
		send(make_instr(hazard_pkg::op_reg, 5'd3, 5'd5, 5'd6), stalls, got);
		check("first issue", 32'd1, 32'(got));
		check("first stall count", 32'd0, stalls);
		idle(4);
	endtask

	task automatic test_latency;
		int   stalls;
		logic got;
		send(make_instr(hazard_pkg::op_imm, 5'd5, 5'd1, 5'd0), stalls, got);
		send(make_instr(hazard_pkg::op_reg, 5'd6, 5'd5, 5'd2), stalls, got);
		check("alu stall count", 32'd3, stalls);
		idle(4);
		send(make_instr(hazard_pkg::op_load, 5'd7, 5'd1, 5'd0), stalls, got);
		send(make_instr(hazard_pkg::op_imm, 5'd8, 5'd7, 5'd0), stalls, got);
		check("load stall count", 32'd4, stalls);
		idle(4);
		send(make_instr(hazard_pkg::op_imm, 5'd0, 5'd1, 5'd0), stalls, got);
		send(make_instr(hazard_pkg::op_reg, 5'd9, 5'd0, 5'd0), stalls, got);
		check("x0 stall count", 32'd0, stalls);
		idle(4);
	endtask

	task automatic test_source_use;
		int   stalls;
		logic got;
		send(make_instr(hazard_pkg::op_imm, 5'd8, 5'd1, 5'd0), stalls, got);
		send(make_instr(hazard_pkg::op_store, 5'd0, 5'd1, 5'd8), stalls, got);
		check("store rs2 stall count", 32'd3, stalls);
		idle(4);
		send(make_instr(hazard_pkg::op_imm, 5'd9, 5'd1, 5'd0), stalls, got);
		send(make_instr(hazard_pkg::op_branch, 5'd0, 5'd0, 5'd9), stalls, got);
		check("branch rs2 stall count", 32'd3, stalls);
		idle(4);
		send(make_instr(hazard_pkg::op_imm, 5'd10, 5'd1, 5'd0), stalls, got);
		send(make_instr(hazard_pkg::op_imm, 5'd2, 5'd1, 5'd10), stalls, got); // rs2 bits are imm
		check("i-type rs2 field stall count", 32'd0, stalls);
		idle(4);
		send(make_instr(hazard_pkg::op_imm, 5'd11, 5'd1, 5'd0), stalls, got);
		send(make_instr(hazard_pkg::op_lui, 5'd12, 5'd11, 5'd11), stalls, got);
		check("lui stall count", 32'd0, stalls);
		send(make_instr(hazard_pkg::op_auipc, 5'd13, 5'd11, 5'd11), stalls, got);
		check("auipc stall count", 32'd0, stalls);
		send(make_instr(hazard_pkg::op_jal, 5'd14, 5'd11, 5'd11), stalls, got);
		check("jal stall count", 32'd0, stalls);
		idle(4);
	endtask

	task automatic test_kill;
		int   stalls;
		int   kills;
		logic got;
		send(make_instr(hazard_pkg::op_imm, 5'd13, 5'd1, 5'd0), stalls, got);
		@(posedge clk);
		instr <= make_instr(hazard_pkg::op_reg, 5'd14, 5'd13, 5'd0);
		branch_taken <= 1'b1;
		@(negedge clk);
		check("kill on strobe", 32'd1, 32'(kill));
		check("stall under kill", 32'd0, 32'(stall));
		@(posedge clk);
		branch_taken <= 1'b0;
		instr_valid <= 1'b0; // squashed word dropped
		@(negedge clk);
		check("kill second cycle", 32'd1, 32'(kill));
		send(make_instr(hazard_pkg::op_reg, 5'd14, 5'd13, 5'd0), stalls, got);
		check("stall count after kill", 32'd1, stalls);
		idle(4);
		kills = 0;
		for (int i = 0; i < 5; i++)
		begin
			@(posedge clk);
			branch_taken <= (i < 2);
			@(negedge clk);
			if (kill)
				kills++;
		end
		check("kill cycles for two strobes", 32'd3, kills);
		idle(2);
	endtask

	task automatic test_illegal;
		int   stalls;
		logic got;
		send(make_instr(hazard_pkg::op_imm, 5'd3, 5'd1, 5'd0), stalls, got);
		send(make_instr(7'b1111111, 5'd4, 5'd3, 5'd3), stalls, got); // fields name a busy register
		check("illegal flag", 32'd1, 32'(illegal));
		check("illegal issued", 32'd0, 32'(got));
		check("illegal stall count", 32'd0, stalls);
		idle(2);
	endtask

	task automatic test_random(input int n);
		logic       hold;
		logic [6:0] op;
		hold = 1'b0;
		repeat (n)
		begin
			@(posedge clk);
			rng = xorshift(rng);
			branch_taken <= (rng[31:28] == 4'd0);
			if (!hold)
			begin
				case (rng[7:4] % 4'd10)
					4'd0: op = hazard_pkg::op_lui;
					4'd1: op = hazard_pkg::op_auipc;
					4'd2: op = hazard_pkg::op_jal;
					4'd3: op = hazard_pkg::op_jalr;
					4'd4: op = hazard_pkg::op_branch;
					4'd5: op = hazard_pkg::op_load;
					4'd6: op = hazard_pkg::op_store;
					4'd7: op = hazard_pkg::op_imm;
					4'd8: op = hazard_pkg::op_reg;
					default: op = 7'b0001011; // custom-0 is not decoded
				endcase
				instr_valid <= (rng[3:1] != 3'd0);
				instr <= make_instr(op, 5'(rng[10:8]), 5'(rng[13:11]), 5'(rng[16:14]));
			end
			@(negedge clk);
			hold = stall;
		end
		idle(2);
	endtask

	initial
	begin
		nrst = 1'b0;
		instr_valid = 1'b0;
		instr = '0;
		branch_taken = 1'b0;
		rng = 32'h8675;
		repeat (reset_cycles) @(posedge clk);
		nrst <= 1'b1;
		test_reset();
		test_latency();
		test_source_use();
		test_kill();
		test_illegal();
		test_random(random_cycles);
		$display("errors: %0d in %0d checks", err_count, check_count);
		if (err_count == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

// File: verilog.f
logic/hazard_pkg.sv
logic/instr_decoder.sv
logic/reg_scoreboard.sv
logic/issue_ctrl.sv
logic/hazard_unit.sv
testbench/hazard_unit_assert.sv
testbench/hazard_unit_tb.sv
